/* hdl/rx_defs.svh */
`ifndef RX_DEFS_SVH
`define RX_DEFS_SVH

// Widths of one code group and one decoded byte
`define RX_CODE_BITS  10
`define RX_BYTE_BITS  8

// Comma sequence as it sits in bits abcdeif
// The first bit sent is the MSB
`define RX_COMMA_BITS  7
`define RX_COMMA_MINUS 7'b0011111   // K28.1/5/7 at negative disparity
`define RX_COMMA_PLUS  7'b1100000   // Same commas at positive disparity

`endif

/* hdl/line_code_pkg.sv */
`include "rx_defs.svh"

package line_code_pkg;

    typedef logic [`RX_CODE_BITS-1:0] code_group_t;  // abcdei in 9..4, fghj in 3..0
    typedef logic [`RX_BYTE_BITS-1:0] byte_t;        // HGF EDCBA, H at the top

    typedef logic [5:0] sub6_t;  // abcdei
    typedef logic [3:0] sub4_t;  // fghj

    typedef enum logic {
        rd_minus,
        rd_plus
    } rd_t;

    // Disparity class of one sub-block
    typedef enum logic [2:0] {
        sd_balanced,
        sd_plus,        // Two more ones than zeros
        sd_minus,       // Two more zeros than ones
        sd_minus_only,  // 111000 and 1100
        sd_plus_only    // 000111 and 0011
    } sub_disp_t;

endpackage

/* hdl/rx_ctrl_pkg.sv */
`include "rx_defs.svh"

package rx_ctrl_pkg;

    // Aligner lock state
    typedef enum logic {
        st_hunt,
        st_locked
    } align_state_t;

    // Bits still to come in the current word, counts down to zero
    typedef logic [$clog2(`RX_CODE_BITS)-1:0] bit_count_t;

endpackage

/* hdl/comma_aligner.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module comma_aligner (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       serial_in,
    output line_code_pkg::code_group_t word,
    output logic                       word_valid
);

    localparam rx_ctrl_pkg::bit_count_t LAST_BIT = rx_ctrl_pkg::bit_count_t'(`RX_CODE_BITS - 1);

    line_code_pkg::code_group_t window;     // Newest bit at bit 0
    rx_ctrl_pkg::align_state_t  state;
    rx_ctrl_pkg::bit_count_t    bits_left;
    logic [`RX_COMMA_BITS-1:0]  head;
    logic                       comma_hit;
    logic                       boundary;

    // The comma occupies the first seven bits of a word
    assign head      = window[`RX_CODE_BITS-1 -: `RX_COMMA_BITS];
    assign comma_hit = (head == `RX_COMMA_MINUS) || (head == `RX_COMMA_PLUS);

    // A comma forces a boundary even while locked
    assign boundary = comma_hit ||
                      ((state == rx_ctrl_pkg::st_locked) && (bits_left == '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window <= '0;
        end else begin
            window <= {window[`RX_CODE_BITS-2:0], serial_in};
        end
    end

    // Lock FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rx_ctrl_pkg::st_hunt;
        end else begin
            case (state)
                rx_ctrl_pkg::st_hunt: begin
                    if (comma_hit)
                        state <= rx_ctrl_pkg::st_locked;
                end
                default: state <= rx_ctrl_pkg::st_locked;  // Stay locked, commas only realign
            endcase
        end
    end

    // Word counter, restarted by every comma
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bits_left <= LAST_BIT;
        end else if (comma_hit || bits_left == '0) begin
            bits_left <= LAST_BIT;
        end else begin
            bits_left <= bits_left - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= boundary;
        end
    end

    always_ff @(posedge clk) begin
        if (boundary)
            word <= window;  // Full word sits in the window here
    end

endmodule

/* hdl/code_group_decoder.sv */
`timescale 1ns/1ps

module code_group_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       word_valid,
    input  line_code_pkg::code_group_t word,
    output logic                       dec_valid,
    output logic                       dec_k,
    output logic                       dec_code_err,
    output line_code_pkg::byte_t       dec_data,
    output line_code_pkg::sub_disp_t   disp6,
    output line_code_pkg::sub_disp_t   disp4
);

    line_code_pkg::sub6_t      s6;
    line_code_pkg::sub4_t      s4;
    line_code_pkg::sub_disp_t  d6;
    line_code_pkg::sub_disp_t  d4;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       v6;
    logic       v4;
    logic       k28;       // K28 6b sub-block
    logic       kx7;       // 6b forms of K23/27/29/30 that take A7
    logic       a7_lo;     // D.17, D.18, D.20 need 0111 at RD-
    logic       a7_hi;     // D.11, D.13, D.14 need 1000 at RD+
    logic       exit_plus;
    logic       exit_minus;
    logic       mix_err;
    logic       a7_err;
    logic       k_flag;
    logic       err_flag;

    function automatic line_code_pkg::sub_disp_t sub_class(
        input int   ones,
        input int   half,
        input logic low_form,
        input logic high_form
    );
        if (low_form)
            return line_code_pkg::sd_minus_only;
        else if (high_form)
            return line_code_pkg::sd_plus_only;
        else if (ones > half)
            return line_code_pkg::sd_plus;
        else if (ones < half)
            return line_code_pkg::sd_minus;
        else
            return line_code_pkg::sd_balanced;
    endfunction

    assign {s6, s4} = word;

    assign d6 = sub_class($countones(s6), 3, s6 == 6'b111000, s6 == 6'b000111);
    assign d4 = sub_class($countones(s4), 2, s4 == 4'b1100, s4 == 4'b0011);

    // 5b/6b lookup, both columns on one line
    always_comb begin
        v6 = 1'b1;
        case (s6)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110, 6'b001111, 6'b110000: edcba = 5'd28;
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            default: begin
                edcba = 5'd0;
                v6    = 1'b0;  // 000000, 111111 and other unused forms
            end
        endcase
    end

    // 3b/4b lookup
    always_comb begin
        v4 = 1'b1;
        case (s4)
            4'b1011, 4'b0100: hgf = 3'd0;
            4'b1001:          hgf = 3'd1;
            4'b0101:          hgf = 3'd2;
            4'b1100, 4'b0011: hgf = 3'd3;
            4'b1101, 4'b0010: hgf = 3'd4;
            4'b1010:          hgf = 3'd5;
            4'b0110:          hgf = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: hgf = 3'd7;
            default: begin
                hgf = 3'd0;
                v4  = 1'b0;
            end
        endcase
        // After 110000 the K table swaps x.1 with x.6 and x.2 with x.5
        if (s6 == 6'b110000 && (s4 == 4'b1001 || s4 == 4'b0110 ||
                                s4 == 4'b0101 || s4 == 4'b1010))
            hgf = ~hgf;
    end

    assign k28   = (s6 == 6'b001111) || (s6 == 6'b110000);
    assign kx7   = (s6 == 6'b111010) || (s6 == 6'b110110) || (s6 == 6'b101110) ||
                   (s6 == 6'b011110) || (s6 == 6'b000101) || (s6 == 6'b001001) ||
                   (s6 == 6'b010001) || (s6 == 6'b100001);
    assign a7_lo = (s6 == 6'b100011) || (s6 == 6'b010011) || (s6 == 6'b001011);
    assign a7_hi = (s6 == 6'b110100) || (s6 == 6'b101100) || (s6 == 6'b011100);

    // Disparity leaving the 6b sub-block must admit the 4b one
    assign exit_plus  = (d6 == line_code_pkg::sd_plus) || (d6 == line_code_pkg::sd_plus_only);
    assign exit_minus = (d6 == line_code_pkg::sd_minus) || (d6 == line_code_pkg::sd_minus_only);
    assign mix_err = (exit_plus && (d4 == line_code_pkg::sd_plus ||
                                    d4 == line_code_pkg::sd_minus_only)) ||
                     (exit_minus && (d4 == line_code_pkg::sd_minus ||
                                     d4 == line_code_pkg::sd_plus_only));

    // A7 only where the run-length rule or a K code calls for it, P7 never there
    assign a7_err = (s4 == 4'b0111 && !(a7_lo || kx7 || s6 == 6'b110000)) ||
                    (s4 == 4'b1000 && !(a7_hi || kx7 || s6 == 6'b001111)) ||
                    (s4 == 4'b1110 && (a7_lo || k28)) ||
                    (s4 == 4'b0001 && (a7_hi || k28));

    assign k_flag   = k28 || (kx7 && (s4 == 4'b0111 || s4 == 4'b1000));
    assign err_flag = !v6 || !v4 || mix_err || a7_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= word_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            dec_data     <= {hgf, edcba};
            dec_k        <= k_flag;
            dec_code_err <= err_flag;
            disp6        <= d6;
            disp4        <= d4;
        end
    end

endmodule

/* hdl/disparity_monitor.sv */
`timescale 1ns/1ps

module disparity_monitor (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dec_valid,
    input  logic                     dec_k,
    input  logic                     dec_code_err,
    input  line_code_pkg::byte_t     dec_data,
    input  line_code_pkg::sub_disp_t disp6,
    input  line_code_pkg::sub_disp_t disp4,
    output logic                     rx_valid,
    output logic                     rx_k,
    output logic                     code_err,
    output logic                     disp_err,
    output line_code_pkg::byte_t     rx_data,
    output line_code_pkg::rd_t       disp
);

    line_code_pkg::rd_t rd_mid;   // Between the two sub-blocks
    line_code_pkg::rd_t rd_end;
    logic               bad_disp;

    // Unbalanced sub-blocks flip the disparity, legal or not
    function automatic line_code_pkg::rd_t rd_after(
        input line_code_pkg::rd_t       rd,
        input line_code_pkg::sub_disp_t cls
    );
        case (cls)
            line_code_pkg::sd_plus:  return line_code_pkg::rd_plus;
            line_code_pkg::sd_minus: return line_code_pkg::rd_minus;
            default:                 return rd;
        endcase
    endfunction

    function automatic logic rd_legal(
        input line_code_pkg::rd_t       rd,
        input line_code_pkg::sub_disp_t cls
    );
        case (cls)
            line_code_pkg::sd_plus, line_code_pkg::sd_minus_only:
                return rd == line_code_pkg::rd_minus;
            line_code_pkg::sd_minus, line_code_pkg::sd_plus_only:
                return rd == line_code_pkg::rd_plus;
            default:
                return 1'b1;
        endcase
    endfunction

    assign rd_mid   = rd_after(disp, disp6);
    assign rd_end   = rd_after(rd_mid, disp4);
    assign bad_disp = !rd_legal(disp, disp6) || !rd_legal(rd_mid, disp4);

    // disp doubles as the running disparity state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid <= 1'b0;
            code_err <= 1'b0;
            disp_err <= 1'b0;
            disp     <= line_code_pkg::rd_minus;
        end else begin
            rx_valid <= dec_valid;
            if (dec_valid) begin
                code_err <= dec_code_err;
                disp_err <= bad_disp;
                disp     <= rd_end;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            rx_data <= dec_data;
            rx_k    <= dec_k;
        end
    end

endmodule

/* hdl/rx_8b10b_top.sv */
`timescale 1ns/1ps

module rx_8b10b_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 serial_in,
    output logic                 rx_valid,
    output logic                 rx_k,
    output logic                 code_err,
    output logic                 disp_err,
    output line_code_pkg::byte_t rx_data,
    output line_code_pkg::rd_t   disp
);

    line_code_pkg::code_group_t word;
    logic                       word_valid;
    logic                       dec_valid;
    logic                       dec_k;
    logic                       dec_code_err;
    line_code_pkg::byte_t       dec_data;
    line_code_pkg::sub_disp_t   disp6;
    line_code_pkg::sub_disp_t   disp4;

    comma_aligner u_aligner (
        .clk        (clk),
        .rst        (rst),
        .serial_in  (serial_in),
        .word       (word),
        .word_valid (word_valid)
    );

    code_group_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .word_valid   (word_valid),
        .word         (word),
        .dec_valid    (dec_valid),
        .dec_k        (dec_k),
        .dec_code_err (dec_code_err),
        .dec_data     (dec_data),
        .disp6        (disp6),
        .disp4        (disp4)
    );

    disparity_monitor u_monitor (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_k        (dec_k),
        .dec_code_err (dec_code_err),
        .dec_data     (dec_data),
        .disp6        (disp6),
        .disp4        (disp4),
        .rx_valid     (rx_valid),
        .rx_k         (rx_k),
        .code_err     (code_err),
        .disp_err     (disp_err),
        .rx_data      (rx_data),
        .disp         (disp)
    );

endmodule

/* verification/rx_8b10b_checker.sv */
`timescale 1ns/1ps

module rx_8b10b_checker (
    input logic clk,
    input logic rst,
    input logic word_valid,
    input logic rx_valid,
    input logic code_err,
    input logic disp_err
);

    logic seen_valid;  // Set by the first output word

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_valid <= 1'b0;
        end else if (rx_valid) begin
            seen_valid <= 1'b1;
        end
    end

    // Words are at least ten bits apart
    no_back_to_back: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid)
        else $error("rx_valid high in two consecutive cycles");

    // Two pipeline stages behind the aligner
    valid_follows_word: assert property (@(posedge clk) disable iff (rst)
        $rose(rx_valid) |-> $past(word_valid, 2))
        else $error("rx_valid rose without word_valid two cycles earlier");

    quiet_flags_before_output: assert property (@(posedge clk) disable iff (rst)
        (!seen_valid && !rx_valid) |-> (!code_err && !disp_err))
        else $error("error flag set before the first rx_valid");

endmodule

bind rx_8b10b_top rx_8b10b_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .word_valid (word_valid),
    .rx_valid   (rx_valid),
    .code_err   (code_err),
    .disp_err   (disp_err)
);

/* verification/tb_rx_8b10b.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module tb_rx_8b10b;

    localparam int DRAIN_CYCLES = 400;
    localparam int MIN_CHECKED  = 230;
    localparam line_code_pkg::byte_t K28_5 = 8'hBC;

    // 5b/6b at negative disparity, D.31 first
    localparam logic [191:0] TBL6 = {
        6'b101011, 6'b011110, 6'b101110, 6'b001110, 6'b110110, 6'b010110, 6'b100110, 6'b110011,
        6'b111010, 6'b011010, 6'b101010, 6'b001011, 6'b110010, 6'b010011, 6'b100011, 6'b011011,
        6'b010111, 6'b011100, 6'b101100, 6'b001101, 6'b110100, 6'b010101, 6'b100101, 6'b111001,
        6'b111000, 6'b011001, 6'b101001, 6'b110101, 6'b110001, 6'b101101, 6'b011101, 6'b100111
    };
    // 3b/4b at negative disparity, x.7 primary first
    localparam logic [31:0] TBL4 = {
        4'b1110, 4'b0110, 4'b1010, 4'b1101, 4'b1100, 4'b0101, 4'b1001, 4'b1011
    };

    logic                       clk;
    logic                       rst;
    logic                       serial_in;
    logic                       rx_valid;
    logic                       rx_k;
    logic                       code_err;
    logic                       disp_err;
    line_code_pkg::byte_t       rx_data;
    line_code_pkg::rd_t         disp;

    logic [15:0]                lfsr;
    line_code_pkg::rd_t         tx_rd;       // Encoder side disparity
    line_code_pkg::code_group_t model_win;
    logic                       model_locked;
    int                         model_left;
    line_code_pkg::code_group_t exp_words[$];
    logic                       exp_check[$];  // Low for words outside the sent framing
    line_code_pkg::rd_t         model_rd;
    logic                       model_rd_known;
    int                         checked;

    rx_8b10b_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_valid  (rx_valid),
        .rx_k      (rx_k),
        .code_err  (code_err),
        .disp_err  (disp_err),
        .rx_data   (rx_data),
        .disp      (disp)
    );

    always #20 clk = ~clk;

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input line_code_pkg::byte_t got,
                              input line_code_pkg::byte_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_disp(input string name, input line_code_pkg::rd_t got,
                              input line_code_pkg::rd_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    // Sub-block class, width 6 or 4
    function automatic line_code_pkg::sub_disp_t sub_class(input logic [5:0] bits,
                                                           input int width);
        int ones;
        ones = $countones(bits);
        if ((width == 6 && bits == 6'b111000) || (width == 4 && bits == 6'b001100))
            return line_code_pkg::sd_minus_only;
        if ((width == 6 && bits == 6'b000111) || (width == 4 && bits == 6'b000011))
            return line_code_pkg::sd_plus_only;
        if (2 * ones > width)
            return line_code_pkg::sd_plus;
        if (2 * ones < width)
            return line_code_pkg::sd_minus;
        return line_code_pkg::sd_balanced;
    endfunction

    function automatic line_code_pkg::rd_t rd_step(input line_code_pkg::rd_t rd,
                                                   input line_code_pkg::sub_disp_t cls,
                                                   inout logic bad);
        case (cls)
            line_code_pkg::sd_plus: begin
                bad = bad || (rd != line_code_pkg::rd_minus);
                return line_code_pkg::rd_plus;
            end
            line_code_pkg::sd_minus: begin
                bad = bad || (rd != line_code_pkg::rd_plus);
                return line_code_pkg::rd_minus;
            end
            line_code_pkg::sd_minus_only: bad = bad || (rd != line_code_pkg::rd_minus);
            line_code_pkg::sd_plus_only:  bad = bad || (rd != line_code_pkg::rd_plus);
            default: ;
        endcase
        return rd;
    endfunction

    // K28.0-7, then K23.7, K27.7, K29.7, K30.7
    function automatic line_code_pkg::byte_t k_byte(input int j);
        if (j < 8)
            return {j[2:0], 5'd28};
        case (j)
            8:       return 8'hF7;
            9:       return 8'hFB;
            10:      return 8'hFD;
            default: return 8'hFE;
        endcase
    endfunction

    function automatic line_code_pkg::code_group_t encode_group(input line_code_pkg::byte_t b,
                                                                input logic k,
                                                                input line_code_pkg::rd_t rd);
        logic [4:0]              x;
        logic [2:0]              y;
        line_code_pkg::sub6_t    s6;
        line_code_pkg::sub4_t    s4;
        logic                    bad;
        logic                    alt;
        line_code_pkg::rd_t      rd1;
        x   = b[4:0];
        y   = b[7:5];
        bad = 1'b0;
        if (k && x == 5'd28) begin
            s6 = (rd == line_code_pkg::rd_minus) ? 6'b001111 : 6'b110000;
        end else begin
            s6 = TBL6[x*6 +: 6];
            if (rd == line_code_pkg::rd_plus && ($countones(s6) != 3 || s6 == 6'b111000))
                s6 = ~s6;
        end
        rd1 = rd_step(rd, sub_class(s6, 6), bad);
        // A7 avoids a run of five
        alt = k || (rd1 == line_code_pkg::rd_minus && (x == 17 || x == 18 || x == 20)) ||
              (rd1 == line_code_pkg::rd_plus && (x == 11 || x == 13 || x == 14));
        if (y == 3'd7 && alt) begin
            s4 = (rd1 == line_code_pkg::rd_minus) ? 4'b0111 : 4'b1000;
        end else begin
            s4 = TBL4[y*4 +: 4];
            if (rd1 == line_code_pkg::rd_plus && ($countones(s4) != 2 || s4 == 4'b1100))
                s4 = ~s4;
            if (k && s6 == 6'b110000 && (y == 1 || y == 2 || y == 5 || y == 6))
                s4 = ~s4;
        end
        return {s6, s4};
    endfunction

    function automatic line_code_pkg::rd_t rd_after_group(input line_code_pkg::code_group_t g,
                                                          input line_code_pkg::rd_t rd,
                                                          inout logic bad);
        line_code_pkg::rd_t mid;
        mid = rd_step(rd, sub_class(g[9:4], 6), bad);
        return rd_step(mid, sub_class({2'b00, g[3:0]}, 4), bad);
    endfunction

    // Searches every data and control code at both disparities
    function automatic void decode_ref(input line_code_pkg::code_group_t g,
                                       input line_code_pkg::rd_t rd,
                                       output line_code_pkg::byte_t b, output logic k,
                                       output logic cerr, output logic derr,
                                       output line_code_pkg::rd_t nrd);
        line_code_pkg::byte_t cand;
        logic                 is_k;
        b    = '0;
        k    = 1'b0;
        cerr = 1'b1;
        derr = 1'b0;
        for (int i = 0; i < 268; i++) begin
            is_k = (i >= 256);
            cand = is_k ? k_byte(i - 256) : i[7:0];
            if (encode_group(cand, is_k, line_code_pkg::rd_minus) == g ||
                encode_group(cand, is_k, line_code_pkg::rd_plus) == g) begin
                b    = cand;
                k    = is_k;
                cerr = 1'b0;
            end
        end
        nrd = rd_after_group(g, rd, derr);
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] cur);
        return {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
    endfunction

    task automatic next_random_byte(output line_code_pkg::byte_t b);
        b = '0;
        repeat (8) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    // Receiver framing: a comma restarts the ten-bit count
    task automatic align_step(input logic b, input logic group_end);
        logic [`RX_COMMA_BITS-1:0] head;
        logic                      comma;
        model_win = {model_win[`RX_CODE_BITS-2:0], b};
        head      = model_win[`RX_CODE_BITS-1 -: `RX_COMMA_BITS];
        comma     = (head == `RX_COMMA_MINUS) || (head == `RX_COMMA_PLUS);
        if (comma || (model_locked && model_left == 0)) begin
            exp_words.push_back(model_win);
            exp_check.push_back(group_end);
        end
        if (comma)
            model_locked = 1'b1;
        model_left = (comma || model_left == 0) ? `RX_CODE_BITS - 1 : model_left - 1;
    endtask

    task automatic send_group(input line_code_pkg::code_group_t g, input int nbits);
        logic bad;
        bad = 1'b0;
        for (int i = `RX_CODE_BITS - 1; i >= `RX_CODE_BITS - nbits; i--) begin
            @(posedge clk);
            serial_in <= g[i];
            align_step(g[i], i == 0);  // A cut group never ends a frame
        end
        tx_rd = rd_after_group(g, tx_rd, bad);
    endtask

    task automatic send_code(input line_code_pkg::byte_t b, input logic k);
        send_group(encode_group(b, k, tx_rd), `RX_CODE_BITS);
    endtask

    task automatic send_random(input int count);
        line_code_pkg::byte_t b;
        repeat (count) begin
            next_random_byte(b);
            send_code(b, 1'b0);
        end
    endtask

    task automatic compare_word(input line_code_pkg::code_group_t g);
        line_code_pkg::byte_t exp_b;
        logic                 exp_k;
        logic                 exp_cerr;
        logic                 exp_derr;
        line_code_pkg::rd_t   exp_rd;
        decode_ref(g, model_rd, exp_b, exp_k, exp_cerr, exp_derr, exp_rd);
        if (!exp_cerr) begin
            check_byte("rx_data", rx_data, exp_b);
            check_flag("rx_k", rx_k, exp_k);
        end
        check_flag("code_err", code_err, exp_cerr);
        if (model_rd_known)
            check_flag("disp_err", disp_err, exp_derr);
        check_disp("disp", disp, exp_rd);  // A comma fixes the disparity again
        model_rd       = exp_rd;
        model_rd_known = 1'b1;
        checked++;
    endtask

    always @(negedge clk) begin
        if (!rst && rx_valid) begin
            if (exp_words.size() == 0) begin
                $display("Output word appeared while none was expected");
                report_failure();
            end else if (exp_check.pop_front()) begin
                compare_word(exp_words.pop_front());
            end else begin
                void'(exp_words.pop_front());
                model_rd_known = 1'b0;
            end
        end
    end

    initial begin
        int n;
        clk            = 1'b0;
        rst            = 1'b1;
        serial_in      = 1'b0;
        lfsr           = 16'd94;
        tx_rd          = line_code_pkg::rd_minus;
        model_win      = '0;
        model_locked   = 1'b0;
        model_left     = `RX_CODE_BITS - 1;
        model_rd       = line_code_pkg::rd_minus;
        model_rd_known = 1'b1;
        checked        = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        send_random(5);       // Hunting, nothing comes out
        tx_rd = line_code_pkg::rd_minus;  // Receiver starts at RD-
        send_code(K28_5, 1'b1);
        send_random(200);

        for (int j = 0; j < 12; j++) begin
            send_code(k_byte(j), 1'b1);
            send_code(K28_5, 1'b1);  // Keeps K28.7 away from data
        end

        // D.0.0 at the wrong disparity
        send_group(encode_group(8'h00, 1'b0,
                   (tx_rd == line_code_pkg::rd_minus) ? line_code_pkg::rd_plus
                                                      : line_code_pkg::rd_minus), 10);
        send_random(3);
        send_code(K28_5, 1'b1);

        send_group(10'b111111_0101, 10);
        send_code(K28_5, 1'b1);
        send_group(10'b011101_1000, 10);  // D.1 with A7 where P7 belongs
        send_code(K28_5, 1'b1);
        send_random(4);

        // One bit lost, then the comma realigns
        send_group(encode_group(8'h5A, 1'b0, tx_rd), 9);
        send_random(3);
        send_code(K28_5, 1'b1);
        send_random(20);

        n = 0;
        while (exp_words.size() != 0 && n < DRAIN_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_words.size() != 0) begin
            $display("Timed out waiting for %0d words", exp_words.size());
            report_failure();
        end else if (checked < MIN_CHECKED) begin
            $display("Only %0d words were checked", checked);
            report_failure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/line_code_pkg.sv
hdl/rx_ctrl_pkg.sv
hdl/comma_aligner.sv
hdl/code_group_decoder.sv
hdl/disparity_monitor.sv
hdl/rx_8b10b_top.sv
verification/rx_8b10b_checker.sv
verification/tb_rx_8b10b.sv

/* Bender.yml */
package:
  name: rx_8b10b

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/line_code_pkg.sv
      - hdl/rx_ctrl_pkg.sv
      - hdl/comma_aligner.sv
      - hdl/code_group_decoder.sv
      - hdl/disparity_monitor.sv
      - hdl/rx_8b10b_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/rx_8b10b_checker.sv
      - verification/tb_rx_8b10b.sv
